//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_fadd_top
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
fp_pkg.sv
fadd_pkg.sv
fadd_if.sv
fadd_align.sv
fadd_sum.sv
lnml_mul.sv
fadd_norm.sv
fadd_top.sv
tb_fadd_top.sv

//--- fadd_align.sv
`timescale 1ns/1ns

module fadd_align (
	input logic clk,
	input logic rst_n,
	input logic [fp_pkg::FLOAT_W-1:0] a,
	input logic [fp_pkg::FLOAT_W-1:0] b,
	input logic in_valid,
	align_if.src out
);

	logic sgn_a, sgn_b;
	logic [fp_pkg::EXP_W-1:0] exp_a, exp_b;
	logic [fp_pkg::FRAC_W-1:0] frc_a, frc_b;
	logic a_ge_b;
	logic [fp_pkg::EXP_W-1:0] diff_ab, diff_ba;
	logic [fadd_pkg::SHAMT_W-1:0] sh_a, sh_b;
	logic signed [fadd_pkg::FIX_W-1:0] fix_a, fix_b;

	// sign-magnitude with hidden 1 to two's complement fixed point
	function automatic logic signed [fadd_pkg::FIX_W-1:0] to_fix(input logic sgn,
		input logic [fp_pkg::FRAC_W-1:0] frc);
		logic [fadd_pkg::FIX_W-1:0] mag;
		mag = fadd_pkg::FIX_W'({1'b1, frc, {fadd_pkg::GUARD_W{1'b0}}});
		return sgn ? -mag : mag;
	endfunction

	// shift counts of 32 or more collapse to 31
	function automatic logic [fadd_pkg::SHAMT_W-1:0] sat_shamt(input logic [fp_pkg::EXP_W-1:0] d);
		return (|d[fp_pkg::EXP_W-1:fadd_pkg::SHAMT_W]) ? '1 : d[fadd_pkg::SHAMT_W-1:0];
	endfunction

	assign {sgn_a, exp_a, frc_a} = a;
	assign {sgn_b, exp_b, frc_b} = b;

	assign fix_a = to_fix(sgn_a, frc_a);
	assign fix_b = to_fix(sgn_b, frc_b);

	assign a_ge_b = exp_a >= exp_b;
	assign diff_ab = exp_a - exp_b;
	assign diff_ba = exp_b - exp_a;
	assign sh_a = a_ge_b ? '0 : sat_shamt(diff_ba); // only the smaller one moves
	assign sh_b = a_ge_b ? sat_shamt(diff_ab) : '0;

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			out.exp_aligned <= a_ge_b ? exp_a : exp_b;
			out.frac_a <= fix_a >>> sh_a;
			out.frac_b <= fix_b >>> sh_b;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out.valid <= 1'b0;
		else
			out.valid <= in_valid;
	end

endmodule

//--- fadd_if.sv
`timescale 1ns/1ns

// stage 1 to stage 2
interface align_if;
	logic valid;
	logic [fp_pkg::EXP_W-1:0] exp_aligned; // larger of the two exponents
	logic signed [fadd_pkg::FIX_W-1:0] frac_a;
	logic signed [fadd_pkg::FIX_W-1:0] frac_b;

	modport src (output valid, exp_aligned, frac_a, frac_b);
	modport dst (input valid, exp_aligned, frac_a, frac_b);
endinterface

// stage 2 to stage 3
interface sum_if;
	logic valid;
	logic [fp_pkg::EXP_W-1:0] exp_aligned;
	logic signed [fadd_pkg::FIX_W-1:0] sum; // two's complement sum
	logic [fadd_pkg::LSH_W-1:0] lsh_onehot;
	logic too_small; // |sum| < 1
	logic sum_ovf; // |sum| >= 2
	logic zero;

	modport src (output valid, exp_aligned, sum, lsh_onehot, too_small, sum_ovf, zero);
	modport dst (input valid, exp_aligned, sum, lsh_onehot, too_small, sum_ovf, zero);
endinterface

//--- fadd_norm.sv
`timescale 1ns/1ns

module fadd_norm #(
	parameter int LSH_DIRECT = 6,
	parameter int A_W = fadd_pkg::FIX_W - 1 - LSH_DIRECT,
	parameter int B_W = fadd_pkg::LSH_W - LSH_DIRECT,
	parameter int P_W = fadd_pkg::FIX_W - 1 - LSH_DIRECT
) (
	input logic clk,
	input logic rst_n,
	sum_if.dst in,
	output logic [fp_pkg::FLOAT_W-1:0] float_out,
	output logic [fp_pkg::OVF_W-1:0] float_ovf,
	output logic out_valid
);

	localparam int FW = fadd_pkg::FIX_W;

	logic [FW-1:0] mag;
	logic signed [fadd_pkg::EXPN_W-1:0] exp_incr, exp_n;
	logic ovf_up, ovf_dn;
	logic [FW-1:0] mant_lsh;
	logic [P_W-1:0] mul_res;

	// stage 3 registers
	logic valid3;
	logic sgn3;
	logic [fp_pkg::EXP_W-1:0] exp3;
	logic [fp_pkg::OVF_W-1:0] ovf3;
	logic [FW-1:0] lsh3, rsh3, org3;
	logic sum_ovf3, small3, big3;

	// stage 4
	logic [FW-1:0] mant_nml;
	logic sgn4;
	logic [fp_pkg::EXP_W-1:0] exp4;
	logic [fp_pkg::FRAC_W-1:0] frac4;
	logic [fp_pkg::OVF_W-1:0] ovf4;
	logic valid4;

	assign mag = in.sum[FW-1] ? -in.sum : in.sum;

	always_comb
	begin
		exp_incr = '0;
		if (in.sum_ovf)
			exp_incr = fadd_pkg::EXPN_W'(1); // right by one
		else if (in.too_small)
		begin
			for (int i = 0; i < fadd_pkg::LSH_W; i++)
				if (in.lsh_onehot[i])
					exp_incr = fadd_pkg::EXPN_W'(-(i + 1));
		end
	end

	assign exp_n = $signed({{(fadd_pkg::EXPN_W-fp_pkg::EXP_W){1'b0}}, in.exp_aligned}) + exp_incr;
	assign ovf_dn = exp_n[fadd_pkg::EXPN_W-1] | in.zero; // negative exponent or exact zero
	assign ovf_up = ~ovf_dn & (exp_n >= $signed(fadd_pkg::EXPN_W'(fp_pkg::EXP_MAX)));

	// small left shifts done directly
	always_comb
	begin
		mant_lsh = '0;
		for (int i = 0; i < LSH_DIRECT; i++)
			if (in.lsh_onehot[i])
				mant_lsh = mag << (i + 1);
	end

	// large left shifts, the product is the mantissa shifted by (k - LSH_DIRECT - 1)
	lnml_mul #(
		.A_W(A_W),
		.B_W(B_W),
		.P_W(P_W)
	) lnml_mul_i (
		.clk(clk),
		.ce(in.valid),
		.op_a(mag[A_W-1:0]),
		.op_b(in.lsh_onehot[fadd_pkg::LSH_W-1:LSH_DIRECT]),
		.res(mul_res)
	);

	always_ff @(posedge clk)
	begin
		if (in.valid)
		begin
			sgn3 <= in.sum[FW-1];
			exp3 <= ovf_dn ? '0 : (ovf_up ? fp_pkg::EXP_W'(fp_pkg::EXP_MAX) : exp_n[fp_pkg::EXP_W-1:0]);
			ovf3[fp_pkg::OVF_UP] <= ovf_up;
			ovf3[fp_pkg::OVF_DN] <= ovf_dn;
			lsh3 <= mant_lsh;
			rsh3 <= (mag >> 1) | FW'(1 << fadd_pkg::GUARD_W); // lowest fraction bit forced
			org3 <= mag;
			sum_ovf3 <= in.sum_ovf;
			small3 <= in.too_small;
			big3 <= ~(|in.lsh_onehot[LSH_DIRECT-1:0]);
		end
	end

	always_comb
	begin
		if (sum_ovf3)
			mant_nml = rsh3;
		else if (small3 && big3)
			mant_nml = {mul_res, {(LSH_DIRECT + 1){1'b0}}};
		else if (small3)
			mant_nml = lsh3;
		else
			mant_nml = org3;
	end

	always_ff @(posedge clk)
	begin
		if (valid3)
		begin
			sgn4 <= sgn3;
			exp4 <= exp3;
			ovf4 <= ovf3;
			if (ovf3[fp_pkg::OVF_DN])
				frac4 <= '0;
			else if (ovf3[fp_pkg::OVF_UP])
				frac4 <= '1; // saturate
			else
				frac4 <= mant_nml[fp_pkg::FRAC_W+fadd_pkg::GUARD_W-1:fadd_pkg::GUARD_W];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid3 <= 1'b0;
			valid4 <= 1'b0;
		end
		else
		begin
			valid3 <= in.valid;
			valid4 <= valid3;
		end
	end

	assign float_out = {sgn4, exp4, frac4};
	assign float_ovf = ovf4;
	assign out_valid = valid4;

endmodule

//--- fadd_pkg.sv
package fadd_pkg;

	// fixed-point mantissa: {2 sign bits, 1 integer bit, 23 fraction bits, 2 guard bits}
	// bit FIX_W-3 carries the weight 1.0
	localparam int FIX_W = 28;
	localparam int GUARD_W = 2;

	// alignment shift count, saturates at 31
	localparam int SHAMT_W = 5;

	// one-hot left-shift code, bit i means a shift of i+1 places
	localparam int LSH_W = 23;

	// signed exponent while normalizing, wide enough for -23 .. 256
	localparam int EXPN_W = 10;

endpackage

//--- fadd_sum.sv
`timescale 1ns/1ns

module fadd_sum (
	input logic clk,
	input logic rst_n,
	align_if.dst in,
	sum_if.src out
);

	logic signed [fadd_pkg::FIX_W-1:0] sum_c;
	logic [fadd_pkg::FIX_W-1:0] mag_c; // |sum|, range [0, 4)
	logic [fadd_pkg::LSH_W-1:0] onehot_c;

	assign sum_c = in.frac_a + in.frac_b;
	assign mag_c = sum_c[fadd_pkg::FIX_W-1] ? -sum_c : sum_c;

	// leading-one search below the integer bit, guard bits not scanned
	always_comb
	begin : lead_one
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < fadd_pkg::LSH_W; i++)
		begin
			onehot_c[i] = mag_c[fadd_pkg::FIX_W-4-i] & ~seen; // bit i -> shift by i+1
			seen = seen | mag_c[fadd_pkg::FIX_W-4-i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (in.valid)
		begin
			out.exp_aligned <= in.exp_aligned;
			out.sum <= sum_c;
			out.lsh_onehot <= onehot_c;
			// magnitude below 1.0
			out.too_small <= ~(|mag_c[fadd_pkg::FIX_W-1:fadd_pkg::FIX_W-3]);
			// two sign bits of the magnitude differ, i.e. 2.0 or more
			out.sum_ovf <= mag_c[fadd_pkg::FIX_W-1] ^ mag_c[fadd_pkg::FIX_W-2];
			out.zero <= ~(|mag_c[fadd_pkg::FIX_W-1:fadd_pkg::GUARD_W]);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
	end

endmodule

//--- fadd_top.sv
`timescale 1ns/1ns

module fadd_top #(
	parameter int LSH_DIRECT = 6 // 1 .. 22, larger shifts go through the multiplier
) (
	input logic clk,
	input logic rst_n,
	input logic [fp_pkg::FLOAT_W-1:0] float_in_a,
	input logic [fp_pkg::FLOAT_W-1:0] float_in_b,
	input logic float_in_valid,
	output logic [fp_pkg::FLOAT_W-1:0] float_out,
	output logic [fp_pkg::OVF_W-1:0] float_ovf, // {overflow, underflow}
	output logic float_out_valid
);

	// multiplier sizing, only the product bits up to the sign bits are needed
	localparam int A_W = fadd_pkg::FIX_W - 1 - LSH_DIRECT;
	localparam int B_W = fadd_pkg::LSH_W - LSH_DIRECT;
	localparam int P_W = A_W;

	align_if align_bus ();
	sum_if sum_bus ();

	fadd_align fadd_align_i (
		.clk(clk),
		.rst_n(rst_n),
		.a(float_in_a),
		.b(float_in_b),
		.in_valid(float_in_valid),
		.out(align_bus)
	);

	fadd_sum fadd_sum_i (
		.clk(clk),
		.rst_n(rst_n),
		.in(align_bus),
		.out(sum_bus)
	);

	fadd_norm #(
		.LSH_DIRECT(LSH_DIRECT),
		.A_W(A_W),
		.B_W(B_W),
		.P_W(P_W)
	) fadd_norm_i (
		.clk(clk),
		.rst_n(rst_n),
		.in(sum_bus),
		.float_out(float_out),
		.float_ovf(float_ovf),
		.out_valid(float_out_valid)
	);

endmodule

//--- fp_pkg.sv
package fp_pkg;

	// ieee 754 single precision
	localparam int FLOAT_W = 32;
	localparam int EXP_W = 8;
	localparam int FRAC_W = 23;

	localparam int EXP_MAX = 255; // all-ones exponent, used when saturating

	// result flag pair {overflow, underflow}
	localparam int OVF_W = 2;
	localparam int OVF_UP = 1;
	localparam int OVF_DN = 0;

endpackage

//--- lnml_mul.sv
`timescale 1ns/1ns

module lnml_mul #(
	parameter int A_W = 21,
	parameter int B_W = 17,
	parameter int P_W = 21 // low product bits kept, at most A_W + B_W
) (
	input logic clk,
	input logic ce,
	input logic [A_W-1:0] op_a,
	input logic [B_W-1:0] op_b,
	output logic [P_W-1:0] res
);

	logic [A_W+B_W-1:0] prod;

	// a one-hot op_b turns this into a shift of op_a
	assign prod = op_a * op_b;

	always_ff @(posedge clk)
	begin
		if (ce)
			res <= prod[P_W-1:0];
	end

endmodule

//--- tb_fadd_top.sv
`timescale 1ns/1ns

module tb_fadd_top;

	localparam int NUM_VEC = 24;
	localparam int LATENCY = 4; // drive edge to the edge where the result is seen
	localparam int TIMEOUT_CYCLES = NUM_VEC * 8 + 50;

	// a, b, expected sum and expected {overflow, underflow} per row
	localparam logic [97:0] VECTORS [NUM_VEC] = '{
		{32'h3f800000, 32'h3f800000, 32'h40000001, 2'b00}, // 1 + 1 with lsb forced
		{32'h3fc00000, 32'h3fc00000, 32'h40400001, 2'b00},
		{32'hbf800000, 32'hbf800000, 32'hc0000001, 2'b00},
		{32'h3fc00000, 32'h3f400000, 32'h40100001, 2'b00}, // right shift after align
		{32'h3f800000, 32'h3f000000, 32'h3fc00000, 2'b00},
		{32'h3f800000, 32'h34000000, 32'h3f800001, 2'b00}, // exponent gap 23
		{32'h3f800000, 32'h33800000, 32'h3f800000, 2'b00}, // gap 24 truncated away
		{32'h40400000, 32'hbe800000, 32'h40300000, 2'b00},
		{32'h4f800000, 32'h3f800000, 32'h4f800000, 2'b00}, // gap 32
		{32'hcf800000, 32'h3f800000, 32'hcf800000, 2'b00},
		{32'h7f000000, 32'h3f800000, 32'h7f000000, 2'b00}, // gap 127
		{32'h3fc00000, 32'hbf800000, 32'h3f000000, 2'b00}, // left 1
		{32'h3f800000, 32'hbf400000, 32'h3e800000, 2'b00}, // left 2
		{32'h3f820000, 32'hbf800000, 32'h3c800000, 2'b00}, // left 6 is the last direct shift
		{32'h3f810000, 32'hbf800000, 32'h3c000000, 2'b00}, // left 7 via the multiplier
		{32'h3f810003, 32'hbf800000, 32'h3c000180, 2'b00},
		{32'h40000000, 32'hbffff000, 32'h3a000000, 2'b00}, // left 12
		{32'h3f800001, 32'hbf800000, 32'h34000000, 2'b00}, // left 23
		{32'h40490fdb, 32'hc0490fdb, 32'h00000000, 2'b01}, // exact zero
		{32'h00a00000, 32'h80800000, 32'h00000000, 2'b01}, // exponent below 0
		{32'h80a00000, 32'h00800000, 32'h80000000, 2'b01}, // sign kept
		{32'h7f000000, 32'h7f000000, 32'h7fffffff, 2'b10},
		{32'hff000000, 32'hff000000, 32'hffffffff, 2'b10},
		{32'h00000000, 32'h00000000, 32'h00800001, 2'b00}  // hidden 1 on exponent 0
	};

	typedef struct packed {
		logic [31:0] sum;
		logic [1:0] flags;
		int issued;
		int idx;
	} expect_t;

	logic clk = 1'b0;
	logic rst_n;
	logic [31:0] float_in_a;
	logic [31:0] float_in_b;
	logic float_in_valid;
	logic [31:0] float_out;
	logic [1:0] float_ovf;
	logic float_out_valid;

	expect_t pending [$];
	expect_t head;
	int cycle = 0;
	int checked = 0;
	logic [31:0] rnd = 32'h8b70140f;

	fadd_top fadd_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.float_in_a(float_in_a),
		.float_in_b(float_in_b),
		.float_in_valid(float_in_valid),
		.float_out(float_out),
		.float_ovf(float_ovf),
		.float_out_valid(float_out_valid)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	initial
	begin : stimulus
		int gap;
		expect_t item;
		rst_n = 1'b0;
		float_in_a = '0;
		float_in_b = '0;
		float_in_valid = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_VEC; i++)
		begin
			@(negedge clk);
			{float_in_a, float_in_b} = VECTORS[i][97:34];
			float_in_valid = 1'b1;
			item.sum = VECTORS[i][33:2];
			item.flags = VECTORS[i][1:0];
			item.issued = cycle;
			item.idx = i;
			pending.push_back(item);
			rnd = xorshift32(rnd);
			gap = (i < 6) ? 0 : int'(rnd[1:0]); // first six back to back
			repeat (gap)
			begin
				@(negedge clk);
				float_in_valid = 1'b0;
			end
		end
		@(negedge clk);
		float_in_valid = 1'b0;
		wait (checked == NUM_VEC);
		repeat (LATENCY + 2) @(negedge clk); // idle tail where a stray beat trips the monitor
		$display("TB PASSED");
		$finish;
	end

	// result monitor
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			assert (float_out_valid == 1'b0)
			else abort_run($sformatf("ERROR: float_out_valid in reset got %h expected 0",
				float_out_valid));
		end
		else if (float_out_valid)
		begin
			assert (pending.size() > 0)
			else abort_run("a result came out with no operands pending");
			head = pending.pop_front();
			assert (cycle - head.issued == LATENCY)
			else abort_run($sformatf("result for entry %0d came %0d cycles after its input",
				head.idx, cycle - head.issued));
			assert (float_out == head.sum)
			else abort_run($sformatf("ERROR: float_out for entry %0d got %h expected %h",
				head.idx, float_out, head.sum));
			assert (float_ovf == head.flags)
			else abort_run($sformatf("ERROR: float_ovf for entry %0d got %h expected %h",
				head.idx, float_ovf, head.flags));
			checked++;
		end
		else if (pending.size() > 0)
		begin
			assert (cycle - pending[0].issued < LATENCY)
			else abort_run($sformatf("no result for entry %0d after %0d cycles",
				pending[0].idx, LATENCY));
		end
	end

	initial
	begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		abort_run($sformatf("the run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

endmodule
